//--- hdl/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  // Data path widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 64;
  localparam int SIZE_W = 24;
  localparam int CTRL_W = 32;

  // Control word
  localparam int BIT_CFG_ENABLE  = 0;
  localparam int BIT_CFG_SRC_INC = 1;
  localparam int BIT_CFG_SRC_DEC = 2;
  localparam int BIT_CFG_INT_EN  = 3;

  // Start command index
  localparam int BIT_CFG_IP_BOT  = 4;
  localparam int BIT_CFG_IP_TOP  = 6;

  // Status word
  localparam int BIT_STS_BUSY    = 0;
  localparam int BIT_STS_FIN     = 1;

endpackage

`default_nettype wire

//--- hdl/dma_cmd_pkg.sv
`default_nettype none

package dma_cmd_pkg;

  // Command table geometry
  localparam int CMD_DEPTH = 8;
  localparam int IP_W      = 3;
  localparam int COUNT_W   = 32;
  localparam int FLAGS_W   = 16;

  // Command flags
  localparam int BIT_CMD_DEST_INC = 0;
  localparam int BIT_CMD_DEST_DEC = 1;
  // Reload addresses when a new command starts
  localparam int BIT_CMD_DEST_RST = 2;
  localparam int BIT_CMD_SRC_RST  = 3;
  localparam int BIT_CMD_CONTINUE = 4;
  // Zero fill of the last sink block
  localparam int BIT_CMD_QUANTUM  = 5;

  typedef enum logic [3:0] {
    IDLE          = 4'h0,
    SETUP_CHANNEL = 4'h1,
    SETUP_COMMAND = 4'h2,
    ACTIVE        = 4'h3,
    END_COMMAND   = 4'h4,
    FLUSH         = 4'h5,
    FINISHED      = 4'h6
  } dma_state_e;

endpackage

`default_nettype wire

//--- hdl/dma_cmd_decode.sv
`default_nettype none

module dma_cmd_decode (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_cmd_wr,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_cmd_idx,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_cmd_src_addr,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_cmd_dest_addr,
  input  logic [dma_cmd_pkg::COUNT_W-1:0]   i_cmd_count,
  input  logic [dma_cmd_pkg::FLAGS_W-1:0]   i_cmd_flags,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_cmd_next,
  input  logic [dma_cfg_pkg::CTRL_W-1:0]    i_control,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_ip,
  output logic                              o_enable,
  output logic                              o_src_inc,
  output logic                              o_src_dec,
  output logic                              o_int_en,
  output logic [dma_cmd_pkg::IP_W-1:0]      o_start_ip,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_src_addr,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_dest_addr,
  output logic [dma_cmd_pkg::COUNT_W-1:0]   o_count,
  output logic [dma_cmd_pkg::IP_W-1:0]      o_next,
  output logic                              o_dest_inc,
  output logic                              o_dest_dec,
  output logic                              o_dest_rst,
  output logic                              o_src_rst,
  output logic                              o_continue,
  output logic                              o_quantum
);

  import dma_cfg_pkg::*;
  import dma_cmd_pkg::*;

  logic [ADDR_W-1:0]  src_tbl   [CMD_DEPTH];
  logic [ADDR_W-1:0]  dest_tbl  [CMD_DEPTH];
  logic [COUNT_W-1:0] count_tbl [CMD_DEPTH];
  logic [FLAGS_W-1:0] flags_tbl [CMD_DEPTH];
  logic [IP_W-1:0]    next_tbl  [CMD_DEPTH];
  logic [FLAGS_W-1:0] flags;

  // Host writes one entry per strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CMD_DEPTH; i++) begin
        src_tbl[i]   <= '0;
        dest_tbl[i]  <= '0;
        count_tbl[i] <= '0;
        flags_tbl[i] <= '0;
        next_tbl[i]  <= '0;
      end
    end else if (i_cmd_wr) begin
      src_tbl[i_cmd_idx]   <= i_cmd_src_addr;
      dest_tbl[i_cmd_idx]  <= i_cmd_dest_addr;
      count_tbl[i_cmd_idx] <= i_cmd_count;
      flags_tbl[i_cmd_idx] <= i_cmd_flags;
      next_tbl[i_cmd_idx]  <= i_cmd_next;
    end
  end

  // Current command
  assign o_src_addr  = src_tbl[i_ip];
  assign o_dest_addr = dest_tbl[i_ip];
  assign o_count     = count_tbl[i_ip];
  assign o_next      = next_tbl[i_ip];
  assign flags       = flags_tbl[i_ip];

  assign o_dest_inc  = flags[BIT_CMD_DEST_INC];
  assign o_dest_dec  = flags[BIT_CMD_DEST_DEC];
  assign o_dest_rst  = flags[BIT_CMD_DEST_RST];
  assign o_src_rst   = flags[BIT_CMD_SRC_RST];
  assign o_continue  = flags[BIT_CMD_CONTINUE];
  assign o_quantum   = flags[BIT_CMD_QUANTUM];

  // Control word fields
  assign o_enable    = i_control[BIT_CFG_ENABLE];
  assign o_src_inc   = i_control[BIT_CFG_SRC_INC];
  assign o_src_dec   = i_control[BIT_CFG_SRC_DEC];
  assign o_int_en    = i_control[BIT_CFG_INT_EN];
  assign o_start_ip  = i_control[BIT_CFG_IP_TOP:BIT_CFG_IP_BOT];

endmodule

`default_nettype wire

//--- hdl/dma_xfer_engine.sv
`default_nettype none

module dma_xfer_engine (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_enable,
  input  logic                              i_src_inc,
  input  logic                              i_src_dec,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_start_ip,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_src_addr,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_dest_addr,
  input  logic [dma_cmd_pkg::COUNT_W-1:0]   i_count,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_next,
  input  logic                              i_dest_inc,
  input  logic                              i_dest_dec,
  input  logic                              i_dest_rst,
  input  logic                              i_src_rst,
  input  logic                              i_continue,
  input  logic                              i_quantum,
  input  logic                              i_src_ready,
  input  logic [dma_cfg_pkg::SIZE_W-1:0]    i_src_size,
  input  logic [dma_cfg_pkg::DATA_W-1:0]    i_src_data,
  input  logic                              i_snk_ready,
  input  logic [dma_cfg_pkg::SIZE_W-1:0]    i_snk_size,
  output logic [dma_cmd_pkg::IP_W-1:0]      o_ip,
  output logic                              o_src_activate,
  output logic                              o_src_strobe,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_src_address,
  output logic                              o_src_flush,
  output logic                              o_snk_activate,
  output logic                              o_snk_strobe,
  output logic [dma_cfg_pkg::DATA_W-1:0]    o_snk_data,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_snk_address,
  output logic                              o_snk_flush,
  output logic                              o_busy,
  output logic                              o_start,
  output logic                              o_word,
  output logic                              o_done
);

  import dma_cfg_pkg::*;
  import dma_cmd_pkg::*;

  dma_state_e         state;
  logic [ADDR_W-1:0]  cur_src;
  logic [ADDR_W-1:0]  cur_dest;
  logic [COUNT_W-1:0] chan_cnt;
  logic [SIZE_W-1:0]  src_cnt;
  logic [SIZE_W-1:0]  snk_cnt;
  // Source word popped this cycle goes to the sink
  logic               fwd;
  logic               run;
  logic               issue;
  logic               drain;
  logic               pad;
  logic               src_close;
  logic               snk_close;

  assign run         = (state == ACTIVE) && i_enable;
  assign o_busy      = (state != IDLE);
  assign o_src_flush = (state == FLUSH);
  assign o_snk_flush = (state == FLUSH);

  always_comb begin
    issue     = 1'b0;
    drain     = 1'b0;
    pad       = 1'b0;
    snk_close = 1'b0;
    src_close = (run || state == FLUSH) && o_src_activate && (src_cnt >= i_src_size);
    case (state)
      ACTIVE: begin
        issue     = run && o_src_activate && o_snk_activate &&
                    (src_cnt < i_src_size) && (snk_cnt < i_snk_size) &&
                    (chan_cnt < i_count);
        snk_close = run && !fwd && o_snk_activate && (snk_cnt >= i_snk_size);
      end
      END_COMMAND: begin
        // Partly filled sink block closes unless it waits for padding
        snk_close = !i_quantum && o_snk_activate && (snk_cnt != '0);
      end
      FLUSH: begin
        drain     = o_src_activate && (src_cnt < i_src_size);
        pad       = !fwd && i_quantum && o_snk_activate && (snk_cnt < i_snk_size);
        snk_close = !fwd && o_snk_activate && (!i_quantum || snk_cnt >= i_snk_size);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= IDLE;
      o_ip           <= '0;
      o_src_activate <= 1'b0;
      o_src_strobe   <= 1'b0;
      o_snk_activate <= 1'b0;
      o_snk_strobe   <= 1'b0;
      o_start        <= 1'b0;
      o_word         <= 1'b0;
      o_done         <= 1'b0;
      fwd            <= 1'b0;
      chan_cnt       <= '0;
      src_cnt        <= '0;
      snk_cnt        <= '0;
    end else begin
      o_start      <= 1'b0;
      o_done       <= 1'b0;
      o_src_strobe <= issue || drain;
      fwd          <= issue;
      o_snk_strobe <= fwd || pad;
      o_word       <= fwd;

      if (issue || drain) begin
        src_cnt <= src_cnt + 1'b1;
      end
      // Sink slot is reserved when the source word is requested
      if (issue || pad) begin
        snk_cnt <= snk_cnt + 1'b1;
      end
      if (issue) begin
        chan_cnt <= chan_cnt + 1'b1;
      end
      if (src_close) begin
        o_src_activate <= 1'b0;
      end
      if (snk_close) begin
        o_snk_activate <= 1'b0;
      end
      if (run && !o_src_activate && i_src_ready) begin
        o_src_activate <= 1'b1;
        src_cnt        <= '0;
      end
      if (run && !o_snk_activate && i_snk_ready) begin
        o_snk_activate <= 1'b1;
        snk_cnt        <= '0;
      end

      case (state)
        IDLE: begin
          if (i_enable) begin
            state   <= SETUP_CHANNEL;
            o_ip    <= i_start_ip;
            o_start <= 1'b1;
          end
        end
        SETUP_CHANNEL: state <= SETUP_COMMAND;
        SETUP_COMMAND: begin
          chan_cnt <= '0;
          state    <= ACTIVE;
        end
        ACTIVE: begin
          if (!i_enable) begin
            state <= FLUSH;
          end else if ((chan_cnt >= i_count) && !fwd) begin
            state <= END_COMMAND;
          end
        end
        END_COMMAND: begin
          if (i_continue) begin
            o_ip  <= i_next;
            state <= SETUP_COMMAND;
          end else begin
            state <= FLUSH;
          end
        end
        FLUSH: begin
          if (!o_src_activate && !o_snk_activate && !fwd) begin
            state  <= FINISHED;
            o_done <= 1'b1;
          end
        end
        FINISHED: begin
          // Held until the host drops enable
          if (!i_enable) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Running addresses and sink data
  always_ff @(posedge clk) begin
    if (fwd) begin
      o_snk_data <= i_src_data;
      if (i_dest_inc) begin
        cur_dest <= cur_dest + 1'b1;
      end else if (i_dest_dec) begin
        cur_dest <= cur_dest - 1'b1;
      end
    end else if (pad) begin
      o_snk_data <= '0;
    end
    if (issue) begin
      if (i_src_inc) begin
        cur_src <= cur_src + 1'b1;
      end else if (i_src_dec) begin
        cur_src <= cur_src - 1'b1;
      end
    end
    if (src_close) begin
      o_src_address <= cur_src;
    end
    if (snk_close) begin
      o_snk_address <= cur_dest;
    end
    if ((state == SETUP_CHANNEL) || (state == SETUP_COMMAND && i_src_rst)) begin
      cur_src       <= i_src_addr;
      o_src_address <= i_src_addr;
    end
    if ((state == SETUP_CHANNEL) || (state == SETUP_COMMAND && i_dest_rst)) begin
      cur_dest      <= i_dest_addr;
      o_snk_address <= i_dest_addr;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dma_status.sv
`default_nettype none

module dma_status (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_busy,
  input  logic                              i_start,
  input  logic                              i_word,
  input  logic                              i_done,
  input  logic                              i_int_en,
  output logic [dma_cfg_pkg::CTRL_W-1:0]    o_status,
  output logic [dma_cfg_pkg::CTRL_W-1:0]    o_word_count,
  output logic                              o_interrupt
);

  import dma_cfg_pkg::*;

  logic fin;

  always_ff @(posedge clk) begin
    if (rst) begin
      fin          <= 1'b0;
      o_word_count <= '0;
      o_interrupt  <= 1'b0;
    end else begin
      o_interrupt <= i_done && i_int_en;
      // New run starts from a clean count
      if (i_start) begin
        fin          <= 1'b0;
        o_word_count <= '0;
      end else begin
        if (i_done) begin
          fin <= 1'b1;
        end
        if (i_word) begin
          o_word_count <= o_word_count + 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_status               = '0;
    o_status[BIT_STS_BUSY] = i_busy;
    o_status[BIT_STS_FIN]  = fin;
  end

endmodule

`default_nettype wire

//--- hdl/dma_top.sv
`default_nettype none

module dma_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_cmd_wr,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_cmd_idx,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_cmd_src_addr,
  input  logic [dma_cfg_pkg::ADDR_W-1:0]    i_cmd_dest_addr,
  input  logic [dma_cmd_pkg::COUNT_W-1:0]   i_cmd_count,
  input  logic [dma_cmd_pkg::FLAGS_W-1:0]   i_cmd_flags,
  input  logic [dma_cmd_pkg::IP_W-1:0]      i_cmd_next,
  input  logic [dma_cfg_pkg::CTRL_W-1:0]    i_control,
  output logic [dma_cfg_pkg::CTRL_W-1:0]    o_status,
  output logic [dma_cfg_pkg::CTRL_W-1:0]    o_word_count,
  output logic                              o_interrupt,
  input  logic                              i_src_ready,
  input  logic [dma_cfg_pkg::SIZE_W-1:0]    i_src_size,
  input  logic [dma_cfg_pkg::DATA_W-1:0]    i_src_data,
  output logic                              o_src_activate,
  output logic                              o_src_strobe,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_src_address,
  output logic                              o_src_flush,
  input  logic                              i_snk_ready,
  input  logic [dma_cfg_pkg::SIZE_W-1:0]    i_snk_size,
  output logic                              o_snk_activate,
  output logic                              o_snk_strobe,
  output logic [dma_cfg_pkg::DATA_W-1:0]    o_snk_data,
  output logic [dma_cfg_pkg::ADDR_W-1:0]    o_snk_address,
  output logic                              o_snk_flush
);

  import dma_cfg_pkg::*;
  import dma_cmd_pkg::*;

  logic               enable;
  logic               src_inc;
  logic               src_dec;
  logic               int_en;
  logic [IP_W-1:0]    start_ip;
  logic [IP_W-1:0]    ip;
  logic [ADDR_W-1:0]  src_addr;
  logic [ADDR_W-1:0]  dest_addr;
  logic [COUNT_W-1:0] count;
  logic [IP_W-1:0]    next;
  logic               dest_inc;
  logic               dest_dec;
  logic               dest_rst;
  logic               src_rst;
  logic               cont;
  logic               quantum;
  logic               busy;
  logic               start;
  logic               word;
  logic               done;

  dma_cmd_decode decode (
    .clk             (clk),
    .rst             (rst),
    .i_cmd_wr        (i_cmd_wr),
    .i_cmd_idx       (i_cmd_idx),
    .i_cmd_src_addr  (i_cmd_src_addr),
    .i_cmd_dest_addr (i_cmd_dest_addr),
    .i_cmd_count     (i_cmd_count),
    .i_cmd_flags     (i_cmd_flags),
    .i_cmd_next      (i_cmd_next),
    .i_control       (i_control),
    .i_ip            (ip),
    .o_enable        (enable),
    .o_src_inc       (src_inc),
    .o_src_dec       (src_dec),
    .o_int_en        (int_en),
    .o_start_ip      (start_ip),
    .o_src_addr      (src_addr),
    .o_dest_addr     (dest_addr),
    .o_count         (count),
    .o_next          (next),
    .o_dest_inc      (dest_inc),
    .o_dest_dec      (dest_dec),
    .o_dest_rst      (dest_rst),
    .o_src_rst       (src_rst),
    .o_continue      (cont),
    .o_quantum       (quantum)
  );

  dma_xfer_engine execute (
    .clk             (clk),
    .rst             (rst),
    .i_enable        (enable),
    .i_src_inc       (src_inc),
    .i_src_dec       (src_dec),
    .i_start_ip      (start_ip),
    .i_src_addr      (src_addr),
    .i_dest_addr     (dest_addr),
    .i_count         (count),
    .i_next          (next),
    .i_dest_inc      (dest_inc),
    .i_dest_dec      (dest_dec),
    .i_dest_rst      (dest_rst),
    .i_src_rst       (src_rst),
    .i_continue      (cont),
    .i_quantum       (quantum),
    .i_src_ready     (i_src_ready),
    .i_src_size      (i_src_size),
    .i_src_data      (i_src_data),
    .i_snk_ready     (i_snk_ready),
    .i_snk_size      (i_snk_size),
    .o_ip            (ip),
    .o_src_activate  (o_src_activate),
    .o_src_strobe    (o_src_strobe),
    .o_src_address   (o_src_address),
    .o_src_flush     (o_src_flush),
    .o_snk_activate  (o_snk_activate),
    .o_snk_strobe    (o_snk_strobe),
    .o_snk_data      (o_snk_data),
    .o_snk_address   (o_snk_address),
    .o_snk_flush     (o_snk_flush),
    .o_busy          (busy),
    .o_start         (start),
    .o_word          (word),
    .o_done          (done)
  );

  dma_status result (
    .clk             (clk),
    .rst             (rst),
    .i_busy          (busy),
    .i_start         (start),
    .i_word          (word),
    .i_done          (done),
    .i_int_en        (int_en),
    .o_status        (o_status),
    .o_word_count    (o_word_count),
    .o_interrupt     (o_interrupt)
  );

endmodule

`default_nettype wire

//--- test/dma_tb.sv
`default_nettype none

module dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import dma_cfg_pkg::*;
  import dma_cmd_pkg::*;

  logic clk;
  logic rst;
  logic i_cmd_wr;
  logic [IP_W-1:0] i_cmd_idx;
  logic [ADDR_W-1:0] i_cmd_src_addr;
  logic [ADDR_W-1:0] i_cmd_dest_addr;
  logic [COUNT_W-1:0] i_cmd_count;
  logic [FLAGS_W-1:0] i_cmd_flags;
  logic [IP_W-1:0] i_cmd_next;
  logic [CTRL_W-1:0] i_control;
  logic [CTRL_W-1:0] o_status;
  logic [CTRL_W-1:0] o_word_count;
  logic o_interrupt;
  logic i_src_ready;
  logic [SIZE_W-1:0] i_src_size;
  logic [DATA_W-1:0] i_src_data;
  logic o_src_activate;
  logic o_src_strobe;
  logic [ADDR_W-1:0] o_src_address;
  logic o_src_flush;
  logic i_snk_ready;
  logic [SIZE_W-1:0] i_snk_size;
  logic o_snk_activate;
  logic o_snk_strobe;
  logic [DATA_W-1:0] o_snk_data;
  logic [ADDR_W-1:0] o_snk_address;
  logic o_snk_flush;

  // Host copy of the command table
  logic [ADDR_W-1:0] tbl_src [CMD_DEPTH];
  logic [ADDR_W-1:0] tbl_dest [CMD_DEPTH];
  logic [COUNT_W-1:0] tbl_count [CMD_DEPTH];
  logic [FLAGS_W-1:0] tbl_flags [CMD_DEPTH];
  logic [IP_W-1:0] tbl_next [CMD_DEPTH];

  logic [31:0] rng = 32'd83011;
  logic [DATA_W-1:0] pool[$];
  logic [DATA_W-1:0] got[$];
  logic [DATA_W-1:0] exp_words[$];
  logic [ADDR_W-1:0] exp_dest;
  logic [ADDR_W-1:0] last_snk_addr;
  logic [ADDR_W-1:0] src_base;
  logic [ADDR_W-1:0] dest_base;
  int src_rd = 0;
  int irq_cnt;
  int viol;
  int flush_cnt;
  int flush_err;
  // Real words the sink must hold before a flush may start
  int flush_min;
  int errors = 0;
  int test_err;
  int tests_run = 0;
  int tests_failed = 0;
  bit stall = 0;
  bit dec_chk = 0;
  bit hung = 0;
  bit snk_act_q = 0;
  bit src_act_q = 0;
  string cur_name = "";

  dma_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_step(rng);
      v = {v[30:0], rng[0]};
    end
    return v;
  endfunction

  // Expected sink words and final destination address for one run
  function automatic int expected_run(input logic [31:0] ctrl, input int base, input int snk_sz);
    int ip;
    int n;
    int hops;
    int k;
    logic [FLAGS_W-1:0] fl;
    ip = ctrl[BIT_CFG_IP_TOP:BIT_CFG_IP_BOT];
    n = 0;
    fl = '0;
    exp_words.delete();
    exp_dest = tbl_dest[ip];
    for (hops = 0; hops < CMD_DEPTH * 2; hops++) begin
      fl = tbl_flags[ip];
      if (hops > 0 && fl[BIT_CMD_DEST_RST]) begin
        exp_dest = tbl_dest[ip];
      end
      for (k = 0; k < tbl_count[ip]; k++) begin
        exp_words.push_back(pool[base + n]);
        n++;
        if (fl[BIT_CMD_DEST_INC]) begin
          exp_dest = exp_dest + 1;
        end else if (fl[BIT_CMD_DEST_DEC]) begin
          exp_dest = exp_dest - 1;
        end
      end
      if (!fl[BIT_CMD_CONTINUE]) begin
        break;
      end
      ip = tbl_next[ip];
    end
    if (fl[BIT_CMD_QUANTUM]) begin
      while (exp_words.size() % snk_sz != 0) begin
        exp_words.push_back('0);
      end
    end
    return n;
  endfunction

  // Source FIFO and ready lines
  always @(posedge clk) begin
    if (o_src_strobe) begin
      src_rd = src_rd + 1;
    end
    i_src_data <= (src_rd < pool.size()) ? pool[src_rd] : '0;
    if (stall) begin
      i_src_ready <= (rand_bits(2) != 0);
      i_snk_ready <= (rand_bits(2) != 0);
    end else begin
      i_src_ready <= 1'b1;
      i_snk_ready <= 1'b1;
    end
  end

  // Sink model and protocol monitor
  always @(negedge clk) begin
    if (!rst) begin
      if (o_snk_strobe) begin
        if (!o_snk_activate) viol++;
        got.push_back(o_snk_data);
      end
      if (o_src_strobe && !o_src_activate) viol++;
      if (o_interrupt) irq_cnt++;
      if (o_src_flush) begin
        flush_cnt++;
        if (got.size() < flush_min || !o_status[BIT_STS_BUSY]) begin
          flush_err++;
        end
      end
      if (o_src_flush != o_snk_flush) begin
        flush_err++;
      end
      if (snk_act_q && !o_snk_activate) begin
        last_snk_addr = o_snk_address;
        if (dec_chk && o_snk_address != dest_base - 64'(got.size())) begin
          $display("Mismatch %s sink address: expected %h, actual %h", cur_name,
                   dest_base - 64'(got.size()), o_snk_address);
          test_err++;
          errors++;
        end
      end
      if (src_act_q && !o_src_activate && dec_chk) begin
        if (o_src_address != src_base - 64'(got.size())) begin
          $display("Mismatch %s source address: expected %h, actual %h", cur_name,
                   src_base - 64'(got.size()), o_src_address);
          test_err++;
          errors++;
        end
      end
      snk_act_q = o_snk_activate;
      src_act_q = o_src_activate;
    end
  end

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
      test_err++;
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timeout in %s: %s did not happen", cur_name, what);
    hung = 1;
    errors++;
    tests_failed++;
  endtask

  task automatic wait_status(input int b, input logic v, input string what);
    for (int t = 0; t < 3000; t++) begin
      @(negedge clk);
      if (o_status[b] == v) return;
    end
    timed_out(what);
  endtask

  task automatic wait_started();
    for (int t = 0; t < 100; t++) begin
      @(negedge clk);
      if (o_status[BIT_STS_BUSY] && !o_status[BIT_STS_FIN]) return;
    end
    timed_out("start of the run");
  endtask

  task automatic wait_words(input int n);
    for (int t = 0; t < 3000; t++) begin
      @(negedge clk);
      if (got.size() >= n) return;
    end
    timed_out("sink words before the enable drop");
  endtask

  task automatic write_cmd(input int idx, input logic [63:0] src, input logic [63:0] dest,
                           input int count, input logic [15:0] flags, input int next);
    @(posedge clk);
    i_cmd_wr <= 1'b1;
    i_cmd_idx <= idx;
    i_cmd_src_addr <= src;
    i_cmd_dest_addr <= dest;
    i_cmd_count <= count;
    i_cmd_flags <= flags;
    i_cmd_next <= next;
    tbl_src[idx] = src;
    tbl_dest[idx] = dest;
    tbl_count[idx] = count;
    tbl_flags[idx] = flags;
    tbl_next[idx] = next;
    @(posedge clk);
    i_cmd_wr <= 1'b0;
  endtask

  task automatic run_test(input string name, input logic [31:0] ctrl, input int src_sz,
                          input int snk_sz, input bit stall_en, input bit dec_en,
                          input int drop_at);
    int exp_n;
    int base;
    int n_at_fin;
    int ip;
    cur_name = name;
    test_err = 0;
    tests_run++;
    ip = ctrl[BIT_CFG_IP_TOP:BIT_CFG_IP_BOT];
    base = src_rd;
    repeat (80) pool.push_back(rand_bits(32));
    exp_n = expected_run(ctrl, base, snk_sz);
    @(posedge clk);
    got.delete();
    irq_cnt = 0;
    viol = 0;
    flush_cnt = 0;
    flush_err = 0;
    flush_min = (drop_at > 0) ? drop_at : exp_n;
    dec_chk = dec_en;
    src_base = tbl_src[ip];
    dest_base = tbl_dest[ip];
    i_src_size <= src_sz;
    i_snk_size <= snk_sz;
    stall <= stall_en;
    i_control <= ctrl;
    wait_started();
    if (hung) return;
    if (drop_at > 0) begin
      wait_words(drop_at);
      if (hung) return;
      @(posedge clk);
      i_control <= ctrl & ~32'h1;
    end
    wait_status(BIT_STS_FIN, 1'b1, "finished bit");
    if (hung) return;
    n_at_fin = got.size();
    if (drop_at == 0) begin
      @(posedge clk);
      i_control <= ctrl & ~32'h1;
    end
    wait_status(BIT_STS_BUSY, 1'b0, "busy clear");
    if (hung) return;
    repeat (20) @(negedge clk);
    if (drop_at > 0) begin
      check_eq("sink words after finish", n_at_fin, got.size());
      if (got.size() >= exp_n) begin
        $display("%s: the transfer ran to its end despite the enable drop", name);
        test_err++;
        errors++;
      end
      for (int i = 0; i < got.size() && i < exp_n; i++) begin
        check_eq($sformatf("word %0d", i), exp_words[i], got[i]);
      end
      check_eq("word count", got.size(), o_word_count);
      check_eq("finished bit", 1, o_status[BIT_STS_FIN]);
    end else begin
      check_eq("sink length", exp_words.size(), got.size());
      for (int i = 0; i < got.size() && i < exp_words.size(); i++) begin
        check_eq($sformatf("word %0d", i), exp_words[i], got[i]);
      end
      check_eq("word count", exp_n, o_word_count);
      check_eq("last sink address", exp_dest, last_snk_addr);
    end
    check_eq("interrupt pulses", ctrl[BIT_CFG_INT_EN], irq_cnt);
    if (viol != 0) begin
      $display("%s: %0d strobes came while the block was not activated", name, viol);
      test_err++;
      errors++;
    end
    if (flush_cnt == 0) begin
      $display("%s: the flush outputs never went high during the run", name);
      test_err++;
      errors++;
    end
    if (flush_err != 0) begin
      $display("%s: the flush outputs were wrong in %0d cycles", name, flush_err);
      test_err++;
      errors++;
    end
    stall <= 1'b0;
    dec_chk = 0;
    if (test_err != 0) tests_failed++;
    $display("%s: %s", name, (test_err == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    rst = 1'b1;
    i_cmd_wr = 1'b0;
    i_cmd_idx = '0;
    i_cmd_src_addr = '0;
    i_cmd_dest_addr = '0;
    i_cmd_count = '0;
    i_cmd_flags = '0;
    i_cmd_next = '0;
    i_control = '0;
    i_src_ready = 1'b0;
    i_src_size = '0;
    i_src_data = '0;
    i_snk_ready = 1'b0;
    i_snk_size = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    write_cmd(0, 64'h100, 64'h2000, 16, 16'h0001, 0);
    write_cmd(1, 64'h1000, 64'h8000, 7, 16'h0011, 4);
    write_cmd(4, 64'h1100, 64'h9000, 9, 16'h0015, 6);
    write_cmd(6, 64'h1200, 64'hA000, 6, 16'h0001, 0);
    write_cmd(2, 64'h300, 64'h3000, 23, 16'h0001, 0);
    write_cmd(3, 64'h5000, 64'h7000, 12, 16'h0002, 0);
    write_cmd(5, 64'h600, 64'h6000, 10, 16'h0021, 0);
    write_cmd(7, 64'h700, 64'hB000, 40, 16'h0001, 0);

    if (!hung) run_test("single_inc", 32'h0B, 8, 8, 0, 0, 0);
    if (!hung) run_test("chain", 32'h1B, 4, 4, 0, 0, 0);
    if (!hung) run_test("small_blocks_stall", 32'h2B, 5, 3, 1, 0, 0);
    if (!hung) run_test("decrement", 32'h3D, 4, 3, 0, 1, 0);
    if (!hung) run_test("quantum_pad", 32'h5B, 4, 4, 0, 0, 0);
    // Interrupt disabled here
    if (!hung) run_test("enable_drop", 32'h73, 8, 8, 0, 0, 10);

    $display("Tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hdl/dma_cfg_pkg.sv
hdl/dma_cmd_pkg.sv
hdl/dma_cmd_decode.sv
hdl/dma_xfer_engine.sv
hdl/dma_status.sv
hdl/dma_top.sv
test/dma_tb.sv

//--- Bender.yml
package:
  name: dma

sources:
  - hdl/dma_cfg_pkg.sv
  - hdl/dma_cmd_pkg.sv
  - hdl/dma_cmd_decode.sv
  - hdl/dma_xfer_engine.sv
  - hdl/dma_status.sv
  - hdl/dma_top.sv
  - target: test
    files:
      - test/dma_tb.sv
